// ==== zports.f ====
source/zx_port_map_pkg.sv
source/zx_reg_pkg.sv
source/io_strobe.sv
source/port_decode.sv
source/mem_pager.sv
source/xt_unlock.sv
source/av_regs.sv
source/zports_top.sv
sim/zports_checker.sv
sim/zports_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := zports_tb
FILELIST  := zports.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/zports_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module zports_tb;

	import zx_port_map_pkg::*;
	import zx_reg_pkg::*;

	localparam logic [7:0] XT_KEY = 8'hAA;
	localparam int clk_period   = 20;
	localparam int reset_cycles = 5;

	// accesses per test, each one 5 cycles long
	localparam int n_decode   = 24;
	localparam int n_page     = 37;
	localparam int n_border   = 16;
	localparam int n_dac      = 12;
	localparam int n_xt       = 35;
	localparam int n_accesses = n_decode + n_page + n_border + n_dac + n_xt;
	localparam int watchdog_ns = (n_accesses * 5 + reset_cycles) * clk_period * 2;

	localparam logic [7:0] rd_ports [12] = '{port_fe, port_fd, port_f7, port_xt_rd,
		port_kmouse, port_kjoy, port_cvx1, port_cvx2, port_sd0, port_sd2, port_sd3, 8'h3B};
	localparam xt_reg_t xt_codes [6] = '{xt_vconfig, xt_pal_addr, xt_pal_data, xt_sf_addr,
		xt_sf_data, xt_border}; // border last, for the readback

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [7:0]  mus_in;
	logic [4:0]  kj_in;
	logic        porthit;
	logic        dataout;
	logic [7:0]  dout;
	logic [7:0]  p7ffd;
	logic [7:0]  peff7;
	logic [5:0]  pent1m_page;
	logic        pent1m_rom;
	logic        pent1m_1m_on;
	logic        pent1m_ram0_0;
	logic [5:0]  border;
	logic [7:0]  psd0;
	logic [7:0]  psd1;
	logic [7:0]  psd2;
	logic [7:0]  psd3;
	logic [7:0]  vcfg;
	logic [7:0]  sp_wa;
	logic [5:0]  sp_wd;
	logic        sp_ws;
	logic [7:0]  sf_wa;
	logic [7:0]  sf_wd;
	logic        sf_ws;

	logic [31:0] seed = 32'hfef;
	logic        mode_dos; // dos level for the next accesses

	zports_top #(.XT_KEY(XT_KEY)) UUT (.*);

	zports_checker #(.XT_KEY(XT_KEY)) chk (.*);

	initial
	begin
		zclk = 1'b0;
		forever
			#(clk_period / 2) zclk = ~zclk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [7:0] rand_byte();
		seed = lcg_next(seed);
		return seed[23:16]; // upper bits are the better ones
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// z80 bus cycles
	task automatic bus_access(input logic is_wr, input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] r;
		logic [7:0] j;
		@(posedge zclk);
		#1;
		r         = rand_byte();
		j         = rand_byte();
		a         = addr;
		din       = data;
		dos       = mode_dos;
		keys_in   = r[4:0];
		tape_read = r[5];
		kj_in     = j[4:0];
		mus_in    = rand_byte();
		iorq_n    = 1'b0;
		rd_n      = is_wr;
		wr_n      = !is_wr;
		repeat (3) @(posedge zclk);
		#1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		@(posedge zclk); // second idle cycle comes from the next call
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		bus_access(1'b1, addr, data);
	endtask

	task automatic io_read(input logic [15:0] addr);
		bus_access(1'b0, addr, rand_byte());
	endtask

	task automatic xt_write(input logic [7:0] code, input logic [7:0] data);
		io_write(port_xt, XT_KEY);
		io_write(port_xt, code);
		io_write(port_xt, data);
	endtask

	// lets the checker finish the last access before renaming
	task automatic begin_test(input string name);
		@(posedge zclk);
		chk.test_name = name;
	endtask

	initial
	begin
		logic [7:0] r;
		logic [7:0] d;
		rst_n     = 1'b0;
		a         = 16'h0000;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		keys_in   = 5'd0;
		tape_read = 1'b0;
		mus_in    = 8'h00;
		kj_in     = 5'd0;
		mode_dos  = 1'b0;
		d         = 8'h00;
		repeat (reset_cycles) @(posedge zclk);
		#1 rst_n = 1'b1;

		begin_test("decode");
		for (int m = 0; m < 2; m++)
		begin
			mode_dos = m[0];
			for (int i = 0; i < 12; i++)
				io_read({rand_byte(), rd_ports[i]});
		end

		begin_test("paging");
		mode_dos = 1'b0;
		io_write(16'hEFF7, 8'h04); // 128k mode
		io_write(16'h7FFD, 8'h20); // lock48
		io_write(16'h7FFD, 8'h07); // blocked
		io_write(16'hEFF7, 8'h00);
		io_write(16'h7FFD, 8'h07);
		for (int i = 0; i < 32; i++)
		begin
			r        = rand_byte();
			mode_dos = (rand_byte() < 8'd64);
			io_write({rand_byte(), r[0] ? port_fd : port_f7}, rand_byte());
		end

		begin_test("border");
		mode_dos = 1'b0;
		for (int i = 0; i < n_border; i++)
			io_write({rand_byte(), port_fe}, rand_byte());

		begin_test("dac");
		io_write({rand_byte(), port_cvx1}, rand_byte());
		io_write({rand_byte(), port_cvx2}, rand_byte());
		io_write({rand_byte(), port_cvx1}, rand_byte());
		io_write({rand_byte(), port_cvx2}, rand_byte());
		for (int m = 0; m < 2; m++)
		begin
			mode_dos = m[0]; // soundrive hidden on the second pass
			io_write({rand_byte(), port_sd0}, rand_byte());
			io_write({rand_byte(), port_sd1}, rand_byte());
			io_write({rand_byte(), port_sd2}, rand_byte());
			io_write({rand_byte(), port_sd3}, rand_byte());
		end

		begin_test("port_xt");
		mode_dos = 1'b0;
		for (int i = 0; i < 6; i++)
		begin
			d = rand_byte();
			xt_write(xt_codes[i], d);
			io_read({rand_byte(), port_xt_rd});
		end

		begin_test("xt_wrong_key");
		io_write(port_xt, ~XT_KEY);
		io_write(port_xt, xt_border);
		io_write(port_xt, ~d); // would repaint the border if the key were taken

		begin_test("xt_abort");
		io_write(port_xt, XT_KEY);
		io_write(16'h54FF, rand_byte()); // undecoded port drops the sequence
		io_write(port_xt, ~XT_KEY);
		io_write(port_xt, XT_KEY);
		io_write(port_xt, xt_border);
		io_write(16'h54FF, rand_byte());
		io_write(port_xt, ~XT_KEY);
		io_read({rand_byte(), port_xt_rd});

		repeat (4) @(posedge zclk);
		$display("checks %0d, errors %0d", chk.check_count, chk.err_count);
		if (chk.err_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		#(watchdog_ns);
		$display("timeout: the test sequence did not finish within %0d ns", watchdog_ns);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/zports_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module zports_checker
#(
	parameter logic [7:0] XT_KEY = 8'hAA
)
(
	input wire        zclk,
	input wire        rst_n,
	input wire [15:0] a,
	input wire [7:0]  din,
	input wire        iorq_n,
	input wire        rd_n,
	input wire        wr_n,
	input wire        dos,
	input wire [4:0]  keys_in,
	input wire        tape_read,
	input wire [7:0]  mus_in,
	input wire [4:0]  kj_in,
	input wire        porthit,
	input wire        dataout,
	input wire [7:0]  dout,
	input wire [7:0]  p7ffd,
	input wire [7:0]  peff7,
	input wire [5:0]  pent1m_page,
	input wire        pent1m_rom,
	input wire        pent1m_1m_on,
	input wire        pent1m_ram0_0,
	input wire [5:0]  border,
	input wire [7:0]  psd0,
	input wire [7:0]  psd1,
	input wire [7:0]  psd2,
	input wire [7:0]  psd3,
	input wire [7:0]  vcfg,
	input wire [7:0]  sp_wa,
	input wire [5:0]  sp_wd,
	input wire        sp_ws,
	input wire [7:0]  sf_wa,
	input wire [7:0]  sf_wd,
	input wire        sf_ws
);

	import zx_port_map_pkg::*;
	import zx_reg_pkg::*;

	string test_name = "reset";
	int    err_count = 0;
	int    check_count = 0;

	// reference model of the port block
	logic [7:0] r_7ffd;
	logic [7:0] r_eff7;
	logic [5:0] r_border;
	logic [7:0] r_psd [4];
	logic [7:0] r_vcfg;
	logic [7:0] r_sp_wa;
	logic [5:0] r_sp_wd;
	logic [7:0] r_sf_wa;
	logic [7:0] r_sf_wd;
	logic [7:0] r_xt_addr;
	xt_state_t  r_xt_st;
	logic [4:0] r_valid; // xt_addr, sp_wa, sp_wd, sf_wa, sf_wd written at least once
	int         r_sp_pulses;
	int         r_sf_pulses;
	int         sp_pulses; // seen on the DUT
	int         sf_pulses;

	// access seen on the bus
	logic        acc_pend;
	logic        acc_wr;
	logic [15:0] acc_a;
	logic [7:0]  acc_d;
	logic        acc_dos;
	int          idle_cnt;

	////////////////////////////////////////////////////////////////////////////
	// reference functions
	function automatic logic hit_ref(input logic [7:0] lo, input logic d);
		case (lo)
			port_fe, port_fd, port_kmouse, port_xt_rd, port_cvx1, port_cvx2: return 1'b1;
			port_kjoy, port_f7, port_sd0, port_sd2, port_sd3: return !d; // hidden in dos
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [7:0] read_ref(input logic [7:0] lo);
		if (lo == port_fe)
			return {1'b1, tape_read, 1'b0, keys_in};
		if (lo == port_kmouse)
			return mus_in;
		if (lo == port_kjoy)
			return {3'b000, kj_in};
		if ((lo == port_xt_rd) && (r_xt_addr == xt_border))
			return {2'b00, r_border};
		return 8'hFF;
	endfunction

	function automatic logic [5:0] fe_border(input logic [7:0] d);
		return {d[1], 1'b0, d[2], 1'b0, d[0], 1'b0};
	endfunction

	function automatic xt_state_t xt_next(input xt_state_t st, input logic [15:0] wa,
		input logic [7:0] wd);
		if (wa != port_xt)
			return xt_idle; // abort
		case (st)
			xt_idle: return (wd == XT_KEY) ? xt_addr : xt_idle;
			xt_addr: return xt_data;
			default: return xt_idle;
		endcase
	endfunction

	task automatic reset_model();
		r_7ffd      = page_reset;
		r_eff7      = page_reset;
		r_border    = 6'd0;
		r_psd       = '{4{8'h00}};
		r_vcfg      = vcfg_reset;
		r_xt_st     = xt_idle;
		r_valid     = 5'd0;
		r_sp_pulses = 0;
		r_sf_pulses = 0;
		sp_pulses   = 0;
		sf_pulses   = 0;
		acc_pend    = 1'b0;
		idle_cnt    = 0;
	endtask

	task automatic apply_write(input logic [15:0] wa, input logic [7:0] wd, input logic wdos);
		logic [7:0] lo;
		lo = wa[7:0];
		if ((lo == port_fd) && !wa[addr_a15] && !(r_7ffd[5] && r_eff7[2]))
			r_7ffd = wd;
		if ((lo == port_f7) && !wa[addr_a12] && !wdos)
			r_eff7 = wd;
		if (lo == port_fe)
		begin
			r_border = fe_border(wd);
			r_psd    = '{4{{8{wd[beeper_bit]}}}};
		end
		if ((lo == port_cvx1) || (lo == port_cvx2))
			r_psd = '{4{wd}};
		if (!wdos)
		begin
			case (lo)
				port_sd0: r_psd[0] = wd;
				port_sd1: r_psd[1] = wd;
				port_sd2: r_psd[2] = wd;
				port_sd3: r_psd[3] = wd;
				default:  ;
			endcase
		end
		if ((wa == port_xt) && (r_xt_st == xt_data))
		begin
			case (r_xt_addr)
				xt_border:   r_border = wd[5:0];
				xt_vconfig:  r_vcfg = wd;
				xt_pal_addr:
				begin
					r_sp_wa    = wd;
					r_valid[1] = 1'b1;
				end
				xt_pal_data:
				begin
					r_sp_wd    = wd[5:0];
					r_valid[2] = 1'b1;
					r_sp_pulses++;
				end
				xt_sf_addr:
				begin
					r_sf_wa    = wd;
					r_valid[3] = 1'b1;
				end
				xt_sf_data:
				begin
					r_sf_wd    = wd;
					r_valid[4] = 1'b1;
					r_sf_pulses++;
				end
				default:     ;
			endcase
		end
		else if ((wa == port_xt) && (r_xt_st == xt_addr))
		begin
			r_xt_addr  = wd;
			r_valid[0] = 1'b1;
		end
		r_xt_st = xt_next(r_xt_st, wa, wd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// comparing
	task automatic compare(input string what, input logic [7:0] exp_v, input logic [7:0] act_v);
		check_count++;
		if (act_v !== exp_v)
		begin
			err_count++;
			$display("Mismatch %s %s: expected %02h, actual %02h", test_name, what, exp_v,
				act_v);
		end
	endtask

	task automatic check_bus();
		logic hit;
		logic rd_act;
		hit    = hit_ref(a[7:0], dos);
		rd_act = !iorq_n && !rd_n;
		compare("porthit", 8'(hit), 8'(porthit));
		compare("dataout", 8'(hit && rd_act), 8'(dataout));
		if (rd_act && ((a[7:0] != port_xt_rd) || r_valid[0])) // readback needs a latched code
			compare("dout", read_ref(a[7:0]), dout);
	endtask

	task automatic check_regs();
		compare("p7ffd", r_eff7[2] ? {3'b000, r_7ffd[4:0]} : r_7ffd, p7ffd);
		compare("peff7", r_eff7[2] ? (r_eff7 & 8'hB1) : r_eff7, peff7);
		compare("pent1m_page", 8'({r_7ffd[7:5], r_7ffd[2:0]}), 8'(pent1m_page));
		compare("pent1m_rom", 8'(r_7ffd[4]), 8'(pent1m_rom));
		compare("pent1m_1m_on", 8'(!r_eff7[2]), 8'(pent1m_1m_on));
		compare("pent1m_ram0_0", 8'(r_eff7[3]), 8'(pent1m_ram0_0));
		compare("border", 8'(r_border), 8'(border));
		compare("psd0", r_psd[0], psd0);
		compare("psd1", r_psd[1], psd1);
		compare("psd2", r_psd[2], psd2);
		compare("psd3", r_psd[3], psd3);
		compare("vcfg", r_vcfg, vcfg);
		if (r_valid[1])
			compare("sp_wa", r_sp_wa, sp_wa);
		if (r_valid[2])
			compare("sp_wd", 8'(r_sp_wd), 8'(sp_wd));
		if (r_valid[3])
			compare("sf_wa", r_sf_wa, sf_wa);
		if (r_valid[4])
			compare("sf_wd", r_sf_wd, sf_wd);
		compare("sp_ws cycles", 8'(r_sp_pulses), 8'(sp_pulses)); // one cycle per write
		compare("sf_ws cycles", 8'(r_sf_pulses), 8'(sf_pulses));
	endtask

	// sample on the falling edge, the bus is driven just after the rising one
	always @(negedge zclk)
	begin
		if (!rst_n)
			reset_model();
		else
		begin
			if (sp_ws)
				sp_pulses++;
			if (sf_ws)
				sf_pulses++;
			check_bus();
			if (!iorq_n && (!wr_n || !rd_n))
			begin
				acc_pend = 1'b1;
				acc_wr   = !wr_n;
				acc_a    = a;
				acc_d    = din;
				acc_dos  = dos;
				idle_cnt = 0;
			end
			else if (acc_pend)
			begin
				idle_cnt++;
				if (idle_cnt == 2) // end of the idle gap
				begin
					acc_pend = 1'b0;
					if (acc_wr)
						apply_write(acc_a, acc_d, acc_dos);
					check_regs();
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/zports_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module zports_top
#(
	parameter logic [7:0] XT_KEY = 8'hAA
)
(
	input  wire         zclk,
	input  wire         rst_n,
	input  wire  [15:0] a,
	input  wire  [7:0]  din,
	input  wire         iorq_n,
	input  wire         rd_n,
	input  wire         wr_n,
	input  wire         dos,
	input  wire  [4:0]  keys_in,
	input  wire         tape_read,
	input  wire  [7:0]  mus_in,
	input  wire  [4:0]  kj_in,
	output logic        porthit,
	output logic        dataout,
	output logic [7:0]  dout,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic [5:0]  border,
	output logic [7:0]  psd0,
	output logic [7:0]  psd1,
	output logic [7:0]  psd2,
	output logic [7:0]  psd3,
	output logic [7:0]  vcfg,
	output logic [7:0]  sp_wa,
	output logic [5:0]  sp_wd,
	output logic        sp_ws,
	output logic [7:0]  sf_wa,
	output logic [7:0]  sf_wd,
	output logic        sf_ws
);

	import zx_reg_pkg::*;

	logic    port_wr;
	logic    port_rd;
	logic    xt_wr;
	xt_reg_t xt_addr;

	io_strobe u_strobe (.zclk, .rst_n, .iorq_n, .rd_n, .wr_n, .port_wr, .port_rd);

	port_decode u_decode (.a, .iorq_n, .rd_n, .dos, .keys_in, .tape_read, .mus_in,
		.kj_in, .xt_addr, .border, .porthit, .dataout, .dout);

	mem_pager u_pager (.zclk, .rst_n, .a, .din, .port_wr, .dos, .p7ffd, .peff7,
		.pent1m_page, .pent1m_rom, .pent1m_1m_on, .pent1m_ram0_0);

	xt_unlock #(.XT_KEY(XT_KEY)) u_xt (.zclk, .rst_n, .a, .din, .port_wr, .xt_addr, .xt_wr);

	av_regs u_av (.zclk, .rst_n, .a, .din, .port_wr, .dos, .xt_addr, .xt_wr, .border,
		.psd0, .psd1, .psd2, .psd3, .vcfg, .sp_wa, .sp_wd, .sp_ws, .sf_wa, .sf_wd, .sf_ws);

	// read strobe must land while the decoder still drives the bus
	a_rd_in_access: assert property (@(posedge zclk) disable iff (!rst_n)
		(port_rd && porthit) |-> dataout);

endmodule

`default_nettype wire

// ==== source/av_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module av_regs
(
	input  wire                    zclk,
	input  wire                    rst_n,
	input  wire  [15:0]            a,
	input  wire  [7:0]             din,
	input  wire                    port_wr,
	input  wire                    dos,
	input  wire zx_reg_pkg::xt_reg_t xt_addr,
	input  wire                    xt_wr,
	output logic [5:0]             border,
	output logic [7:0]             psd0,
	output logic [7:0]             psd1,
	output logic [7:0]             psd2,
	output logic [7:0]             psd3,
	output logic [7:0]             vcfg,
	output logic [7:0]             sp_wa,
	output logic [5:0]             sp_wd,
	output logic                   sp_ws,
	output logic [7:0]             sf_wa,
	output logic [7:0]             sf_wd,
	output logic                   sf_ws
);

	import zx_port_map_pkg::*;
	import zx_reg_pkg::*;

	logic [7:0] loa;
	logic       fe_wr;
	logic       cv_wr; // covox, all four channels
	logic       sd_wr; // soundrive, one channel
	logic [7:0] beep;

	assign loa   = a[7:0];
	assign fe_wr = port_wr && (loa == port_fe);
	assign cv_wr = port_wr && ((loa == port_cvx1) || (loa == port_cvx2));
	assign sd_wr = port_wr && !dos && ((loa == port_sd0) || (loa == port_sd1) ||
	                                   (loa == port_sd2) || (loa == port_sd3));
	assign beep  = {8{din[beeper_bit]}};

	////////////////////////////////////////////////////////////////////////////
	// border, dac and video config
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= 6'd0;
			psd0   <= page_reset;
			psd1   <= page_reset;
			psd2   <= page_reset;
			psd3   <= page_reset;
			vcfg   <= vcfg_reset;
		end
		else
		begin
			if (fe_wr)
			begin
				border <= {din[1], 1'b0, din[2], 1'b0, din[0], 1'b0}; // grb into 6 bit colour
				{psd0, psd1, psd2, psd3} <= {4{beep}};
			end
			if (cv_wr)
				{psd0, psd1, psd2, psd3} <= {4{din}};
			if (sd_wr)
			begin
				case (loa)
					port_sd0: psd0 <= din;
					port_sd1: psd1 <= din;
					port_sd2: psd2 <= din;
					default:  psd3 <= din;
				endcase
			end
			if (xt_wr && (xt_addr == xt_border))
				border <= din[5:0];
			if (xt_wr && (xt_addr == xt_vconfig))
				vcfg <= din;
		end
	end

	// palette and sprite file write ports
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sp_ws <= 1'b0;
			sf_ws <= 1'b0;
		end
		else
		begin
			sp_ws <= xt_wr && (xt_addr == xt_pal_data);
			sf_ws <= xt_wr && (xt_addr == xt_sf_data);
		end
	end

	always_ff @(posedge zclk)
	begin
		if (xt_wr)
		begin
			case (xt_addr)
				xt_pal_addr: sp_wa <= din;
				xt_pal_data: sp_wd <= din[5:0];
				xt_sf_addr:  sf_wa <= din;
				xt_sf_data:  sf_wd <= din;
				default:     ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/xt_unlock.sv ====
`timescale 1ns/1ps
`default_nettype none

module xt_unlock
#(
	parameter logic [7:0] XT_KEY = 8'hAA
)
(
	input  wire                 zclk,
	input  wire                 rst_n,
	input  wire  [15:0]         a,
	input  wire  [7:0]          din,
	input  wire                 port_wr,
	output zx_reg_pkg::xt_reg_t xt_addr,
	output logic                xt_wr
);

	import zx_port_map_pkg::*;
	import zx_reg_pkg::*;

	xt_state_t xt_st;
	logic      xt_hit;

	assign xt_hit = port_wr && (a == port_xt);
	assign xt_wr  = xt_hit && (xt_st == xt_data); // data byte, same cycle as the strobe

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			xt_st <= xt_idle;
		else if (port_wr && !xt_hit)
			xt_st <= xt_idle; // any other port write drops the sequence
		else if (xt_hit)
		begin
			case (xt_st)
				xt_idle:             xt_st <= (din == XT_KEY) ? zx_reg_pkg::xt_addr : xt_idle;
				zx_reg_pkg::xt_addr: xt_st <= xt_data;
				default:             xt_st <= xt_idle;
			endcase
		end
	end

	// register code of the current sequence
	always_ff @(posedge zclk)
	begin
		if (xt_hit && (xt_st == zx_reg_pkg::xt_addr))
			xt_addr <= xt_reg_t'(din);
	end

	// a data byte always goes out with a latched register code
	a_xt_wr_code: assert property (@(posedge zclk) disable iff (!rst_n)
		xt_wr |-> !$isunknown(xt_addr));

endmodule

`default_nettype wire

// ==== source/mem_pager.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_pager
(
	input  wire         zclk,
	input  wire         rst_n,
	input  wire  [15:0] a,
	input  wire  [7:0]  din,
	input  wire         port_wr,
	input  wire         dos,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0
);

	import zx_port_map_pkg::*;

	logic [7:0] p7ffd_int; // 2..0 page, 3 screen, 4 rom, 5 lock48, 7..6 high page
	logic [7:0] peff7_int; // 2 blocks the 1 meg extension
	logic       block1m;
	logic       block7ffd;
	logic       fd_wr;
	logic       f7_wr;

	assign block1m   = peff7_int[2];
	assign block7ffd = p7ffd_int[5] & block1m; // 48k lock only in 128k mode
	assign fd_wr     = port_wr && (a[7:0] == port_fd) && !a[addr_a15] && !block7ffd;
	assign f7_wr     = port_wr && (a[7:0] == port_f7) && !a[addr_a12] && !dos;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_int <= 8'h00;
			peff7_int <= 8'h00;
		end
		else
		begin
			if (fd_wr)
				p7ffd_int <= din;
			if (f7_wr)
				peff7_int <= din;
		end
	end

	// high page bits vanish with the extension off
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_int[7:5]), p7ffd_int[4:0]};
	assign peff7 = block1m ? {peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]}
	                       : peff7_int;

	assign pent1m_page   = {p7ffd_int[7:5], p7ffd_int[2:0]};
	assign pent1m_rom    = p7ffd_int[4];
	assign pent1m_1m_on  = ~peff7_int[2];
	assign pent1m_ram0_0 = peff7_int[3];

endmodule

`default_nettype wire

// ==== source/port_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_decode
(
	input  wire [15:0]             a,
	input  wire                    iorq_n,
	input  wire                    rd_n,
	input  wire                    dos,
	input  wire [4:0]              keys_in,
	input  wire                    tape_read,
	input  wire [7:0]              mus_in,
	input  wire [4:0]              kj_in,
	input  wire zx_reg_pkg::xt_reg_t xt_addr,
	input  wire [5:0]              border,
	output logic                   porthit,
	output logic                   dataout,
	output logic [7:0]             dout
);

	import zx_port_map_pkg::*;
	import zx_reg_pkg::*;

	logic [7:0] loa;
	logic       hit_any;  // ports seen in every mode
	logic       hit_norm; // ports hidden in dos mode

	assign loa = a[7:0];

	always_comb
	begin
		hit_any  = (loa == port_fe) || (loa == port_fd) || (loa == port_kmouse) ||
		           (loa == port_xt_rd) || (loa == port_cvx1) || (loa == port_cvx2);
		hit_norm = (loa == port_kjoy) || (loa == port_f7) || (loa == port_sd0) ||
		           (loa == port_sd2) || (loa == port_sd3);
		porthit  = hit_any | (hit_norm & ~dos);
	end

	// drive the z80 data bus only on a read of our own port
	assign dataout = porthit & ~iorq_n & ~rd_n;

	////////////////////////////////////////////////////////////////////////////
	// read multiplexer
	always_comb
	begin
		dout = 8'hFF; // unused bits float high on the real bus
		if (loa == port_fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (loa == port_kmouse)
			dout = mus_in;
		else if (loa == port_kjoy)
			dout = {3'b000, kj_in};
		else if ((loa == port_xt_rd) && (xt_addr == xt_border))
			dout = {2'b00, border}; // only the border is readable so far
	end

endmodule

`default_nettype wire

// ==== source/io_strobe.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_strobe
(
	input  wire  zclk,
	input  wire  rst_n,
	input  wire  iorq_n,
	input  wire  rd_n,
	input  wire  wr_n,
	output logic port_wr,
	output logic port_rd
);

	logic iowr_reg; // bus write level, sampled
	logic iord_reg;
	logic iowr_dly; // one cycle older copy for edge detect
	logic iord_dly;

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_reg <= 1'b0;
			iord_reg <= 1'b0;
			iowr_dly <= 1'b0;
			iord_dly <= 1'b0;
			port_wr  <= 1'b0;
			port_rd  <= 1'b0;
		end
		else
		begin
			iowr_reg <= ~(iorq_n | wr_n);
			iord_reg <= ~(iorq_n | rd_n);
			iowr_dly <= iowr_reg;
			iord_dly <= iord_reg;
			port_wr  <= iowr_reg & ~iowr_dly; // rising edge of the sampled level
			port_rd  <= iord_reg & ~iord_dly;
		end
	end

	// a z80 cycle is either a read or a write
	a_wr_rd_excl: assert property (@(posedge zclk) disable iff (!rst_n)
		!(port_wr && port_rd));

endmodule

`default_nettype wire

// ==== source/zx_reg_pkg.sv ====
`default_nettype none

package zx_reg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// port xt unlock sequence
	typedef enum logic [1:0]
	{
		xt_idle = 2'd0, // waiting for the key
		xt_addr = 2'd1, // next byte is the register code
		xt_data = 2'd2  // next byte goes to the register
	} xt_state_t;

	// register codes behind #55FF
	typedef enum logic [7:0]
	{
		xt_border   = 8'h00,
		xt_vconfig  = 8'h08,
		xt_pal_addr = 8'h09,
		xt_pal_data = 8'h0A,
		xt_sf_addr  = 8'h0B,
		xt_sf_data  = 8'h0C
	} xt_reg_t;

	// register values after reset
	localparam logic [7:0] vcfg_reset = 8'h00;
	localparam logic [7:0] page_reset = 8'h00;
endpackage

`default_nettype wire

// ==== source/zx_port_map_pkg.sv ====
`default_nettype none

package zx_port_map_pkg;

	////////////////////////////////////////////////////////////////////////////
	// low address byte of the decoded ports
	localparam logic [7:0] port_fe     = 8'hFE; // keyboard, tape, border, beeper
	localparam logic [7:0] port_fd     = 8'hFD; // #7FFD paging
	localparam logic [7:0] port_f7     = 8'hF7; // #EFF7 paging
	localparam logic [7:0] port_xt_rd  = 8'hEF; // port xt readback
	localparam logic [7:0] port_kmouse = 8'hDF;
	localparam logic [7:0] port_kjoy   = 8'h1F; // kempston, shares #1F with sd1
	localparam logic [7:0] port_cvx1   = 8'hFB; // covox
	localparam logic [7:0] port_cvx2   = 8'hDD;
	localparam logic [7:0] port_sd0    = 8'h0F; // soundrive channels
	localparam logic [7:0] port_sd1    = 8'h1F;
	localparam logic [7:0] port_sd2    = 8'h4F;
	localparam logic [7:0] port_sd3    = 8'h5F;

	// port xt needs the whole address
	localparam logic [15:0] port_xt = 16'h55FF;

	// bit positions
	localparam int addr_a15   = 15;
	localparam int addr_a12   = 12;
	localparam int beeper_bit = 4; // din bit of #FE
endpackage

`default_nettype wire
